//--- list.f
verilog/exCorePkg.sv
verilog/exAluOpPkg.sv
verilog/exCarrySelectAdder.sv
verilog/exCompareFlags.sv
verilog/exAlu.sv
verilog/exStatusReg.sv
verilog/exAluSlice.sv
test/exAluSliceTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the ALU slice testbench with Verilator, run it and judge the log.

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_EXE=simExAluSlice
LOG=sim.log

verilator --binary --timing --top-module exAluSliceTb \
	-Mdir "$OBJ_DIR" -o "$SIM_EXE" -f list.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/$SIM_EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
	echo "simulation ended without a pass line"
	exit 1
fi

echo "simulation passed"
exit 0

//--- test/exAluSliceTb.sv
// top-level testbench that drives the ALU slice from a stimulus table and checks it against a model
`default_nettype none

module exAluSliceTb;

	import exCorePkg::*;
	import exAluOpPkg::*;

	localparam int RESET_CYCLES  = 8;
	localparam int VALID_TIMEOUT = 16;
	localparam int NUM_ROWS      = 54;

	// operand sources for a row
	localparam logic [2:0] OPND_RAND   = 3'd0;
	localparam logic [2:0] OPND_ZERO   = 3'd1;
	localparam logic [2:0] OPND_ONES   = 3'd2;
	localparam logic [2:0] OPND_MINMAX = 3'd3;
	localparam logic [2:0] OPND_MAXMIN = 3'd4;
	localparam logic [2:0] OPND_CARRY  = 3'd5;
	localparam logic [2:0] OPND_SAME   = 3'd6;

	typedef struct packed {
		aluIxt_t    ixt;
		logic       hold;
		logic       srLoad;
		srBits_t    loadVal;
		logic [2:0] opnd;
	} row_t;

	typedef struct packed {
		logic    flag;
		regVal_t val;
	} laneRes_t;

	typedef struct packed {
		regVal_t val;
		srBits_t sr;
	} expect_t;

	// each row is ixt byte {cc, qword, zext, op}, hold, srLoad, load value {s, t} and operands
	localparam row_t ROWS [NUM_ROWS] = '{
		'{8'h00, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h10, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h01, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h11, 1'b0, 1'b0, 2'b00, OPND_MAXMIN},
		'{8'h01, 1'b0, 1'b0, 2'b00, OPND_MINMAX},
		'{8'h05, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h16, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h07, 1'b0, 1'b0, 2'b00, OPND_ONES},
		'{8'h1B, 1'b0, 1'b0, 2'b00, OPND_ZERO},
		'{8'h0B, 1'b0, 1'b0, 2'b00, OPND_RAND},
		// load against a compare that would set T
		'{8'h2C, 1'b0, 1'b1, 2'b10, OPND_ZERO},
		// 64-bit carry chain through T
		'{8'h22, 1'b0, 1'b0, 2'b00, OPND_CARRY},
		'{8'h22, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h23, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h23, 1'b0, 1'b0, 2'b00, OPND_ZERO},
		'{8'h21, 1'b0, 1'b0, 2'b00, OPND_MINMAX},
		'{8'h26, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h2B, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h02, 1'b0, 1'b0, 2'b00, OPND_CARRY},
		'{8'h13, 1'b0, 1'b0, 2'b00, OPND_RAND},
		// compares and TST
		'{8'h0C, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h28, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h29, 1'b0, 1'b0, 2'b00, OPND_MINMAX},
		'{8'h1D, 1'b0, 1'b0, 2'b00, OPND_MAXMIN},
		'{8'h2A, 1'b0, 1'b0, 2'b00, OPND_MINMAX},
		'{8'h0E, 1'b0, 1'b0, 2'b00, OPND_MAXMIN},
		'{8'h2E, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h04, 1'b0, 1'b0, 2'b00, OPND_ZERO},
		'{8'h24, 1'b0, 1'b0, 2'b00, OPND_ONES},
		'{8'h09, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h0A, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h2D, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h2C, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h0E, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h08, 1'b0, 1'b0, 2'b00, OPND_RAND},
		// packed lanes with the high lane in S
		'{8'h3C, 1'b0, 1'b0, 2'b00, OPND_SAME},
		'{8'h32, 1'b0, 1'b0, 2'b00, OPND_CARRY},
		'{8'h33, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h3F, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h3E, 1'b0, 1'b0, 2'b00, OPND_MINMAX},
		'{8'h3F, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h39, 1'b0, 1'b0, 2'b00, OPND_MAXMIN},
		'{8'h34, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h3B, 1'b0, 1'b0, 2'b00, OPND_RAND},
		// stalled issues are dropped even with a load
		'{8'h20, 1'b1, 1'b0, 2'b00, OPND_RAND},
		'{8'h2C, 1'b1, 1'b1, 2'b11, OPND_SAME},
		'{8'h22, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h0F, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'hE2, 1'b0, 1'b0, 2'b00, OPND_RAND},
		'{8'h00, 1'b0, 1'b1, 2'b01, OPND_RAND},
		'{8'h2C, 1'b0, 1'b1, 2'b00, OPND_SAME},
		'{8'h21, 1'b1, 1'b0, 2'b00, OPND_RAND},
		'{8'h21, 1'b1, 1'b0, 2'b00, OPND_RAND},
		'{8'h21, 1'b0, 1'b0, 2'b00, OPND_RAND}
	};

	logic    clock;
	logic    rst;
	logic    issue;
	logic    hold;
	regVal_t regValRs;
	regVal_t regValRt;
	aluIxt_t ixt;
	logic    srLoad;
	srBits_t srLoadVal;
	regVal_t regOutVal;
	logic    outValid;
	srBits_t sr;

	logic [15:0] lfsrState = 16'd23342;
	int          rowIdx;
	regVal_t     opRs;
	regVal_t     opRt;
	expect_t     modelOut;
	regVal_t     expVal;
	logic        expValid;
	srBits_t     expSr;

	exAluSlice u_dut (
		.clock     (clock),
		.rst       (rst),
		.issue     (issue),
		.hold      (hold),
		.regValRs  (regValRs),
		.regValRt  (regValRt),
		.ixt       (ixt),
		.srLoad    (srLoad),
		.srLoadVal (srLoadVal),
		.regOutVal (regOutVal),
		.outValid  (outValid),
		.sr        (sr)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrStep(logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomWord(output regVal_t w);
		w = '0;
		for (int i = 0; i < REG_WIDTH; i++) begin
			lfsrState = lfsrStep(lfsrState);
			w = {w[REG_WIDTH-2:0], lfsrState[0]};
		end
	endtask

	task automatic pickOperands(input logic [2:0] kind, output regVal_t rs, output regVal_t rt);
		case (kind)
			OPND_ZERO: begin
				rs = '0;
				rt = '0;
			end
			OPND_ONES: begin
				rs = '1;
				rt = '1;
			end
			OPND_MINMAX: begin
				rs = 64'h8000_0000_8000_0000;
				rt = 64'h7fff_ffff_7fff_ffff;
			end
			OPND_MAXMIN: begin
				rs = 64'h7fff_ffff_7fff_ffff;
				rt = 64'h8000_0000_8000_0000;
			end
			OPND_CARRY: begin
				rs = '1;
				rt = 64'd1;
			end
			OPND_SAME: begin
				randomWord(rs);
				rt = rs;
			end
			default: begin
				randomWord(rs);
				randomWord(rt);
			end
		endcase
	endtask

	// one operation at 32 or 64 bits with flagIn as carry, borrow or select
	function automatic laneRes_t laneModel(aluOp_t op, regVal_t a, regVal_t b, logic wide,
		logic flagIn);
		regVal_t            mask;
		regVal_t            signBit;
		regVal_t            ma;
		regVal_t            mb;
		regVal_t            sa;
		regVal_t            sb;
		logic [REG_WIDTH:0] sum;
		logic [REG_WIDTH:0] diff;
		laneRes_t           r;

		mask    = wide ? {REG_WIDTH{1'b1}} : 64'h0000_0000_ffff_ffff;
		signBit = wide ? 64'h8000_0000_0000_0000 : 64'h0000_0000_8000_0000;
		ma      = a & mask;
		mb      = b & mask;
		sum     = {1'b0, ma} + {1'b0, mb} + {64'd0, flagIn};
		diff    = {1'b0, ma} - {1'b0, mb} - {64'd0, flagIn};

		// flipping the sign bit turns signed order into unsigned order
		sa = ma ^ signBit;
		sb = mb ^ signBit;

		r.flag = flagIn;
		r.val  = '0;
		case (op)
			OP_ADD:   r.val = ma + mb;
			OP_SUB:   r.val = ma - mb;
			OP_ADC: begin
				r.val  = sum[REG_WIDTH-1:0];
				r.flag = wide ? sum[REG_WIDTH] : sum[LANE_WIDTH];
			end
			OP_SBB: begin
				r.val  = diff[REG_WIDTH-1:0];
				r.flag = diff[REG_WIDTH];
			end
			OP_AND:   r.val = ma & mb;
			OP_OR:    r.val = ma | mb;
			OP_XOR:   r.val = ma ^ mb;
			OP_NOR:   r.val = ~(ma | mb);
			OP_TST:   r.flag = ((ma & mb) == '0);
			OP_CMPNE: r.flag = (ma != mb);
			OP_CMPEQ: r.flag = (ma == mb);
			OP_CMPHS: r.flag = (ma >= mb);
			OP_CMPHI: r.flag = (ma > mb);
			OP_CMPGE: r.flag = (sa >= sb);
			OP_CMPGT: r.flag = (sa > sb);
			OP_CSELT: r.val = flagIn ? ma : mb;
		endcase
		r.val = r.val & mask;
		return r;
	endfunction

	function automatic expect_t aluModel(aluIxt_t op, regVal_t rs, regVal_t rt, srBits_t srIn);
		laneRes_t lo;
		laneRes_t hi;
		expect_t  e;

		e.sr = srIn;
		if (op.qword && op.zext) begin
			lo     = laneModel(op.op, rs, rt, 1'b0, srIn.t);
			hi     = laneModel(op.op, rs >> LANE_WIDTH, rt >> LANE_WIDTH, 1'b0, srIn.s);
			e.val  = {hi.val[LANE_WIDTH-1:0], lo.val[LANE_WIDTH-1:0]};
			e.sr.t = lo.flag;
			e.sr.s = hi.flag;
		end else if (op.qword) begin
			lo     = laneModel(op.op, rs, rt, 1'b1, srIn.t);
			e.val  = lo.val;
			e.sr.t = lo.flag;
		end else begin
			lo     = laneModel(op.op, rs, rt, 1'b0, srIn.t);
			e.sr.t = lo.flag;
			if (op.zext) begin
				e.val = lo.val;
			end else begin
				e.val = {{LANE_WIDTH{lo.val[LANE_WIDTH-1]}}, lo.val[LANE_WIDTH-1:0]};
			end
		end
		return e;
	endfunction

	task automatic reportFail();
		$display("TEST FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkVal(string name, regVal_t got, regVal_t exp);
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h (row %0d)", name, got, exp, rowIdx);
			reportFail();
		end
	endtask

	task automatic checkSr(string name, srBits_t got, srBits_t exp);
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h (row %0d)", name, got, exp, rowIdx);
			reportFail();
		end
	endtask

	task automatic checkFlag(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h (row %0d)", name, got, exp, rowIdx);
			reportFail();
		end
	endtask

	task automatic waitValid();
		int waited;

		waited = 0;
		while (!outValid) begin
			if (waited == VALID_TIMEOUT) begin
				$display("timeout: outValid never rose for row %0d", rowIdx);
				reportFail();
			end
			@(negedge clock);
			waited++;
		end
	endtask

	task automatic checkOutputs();
		checkVal("regOutVal", regOutVal, expVal);
		checkFlag("outValid", outValid, expValid);
		checkSr("sr", sr, expSr);
	endtask

	initial begin
		rst       = 1'b1;
		issue     = 1'b0;
		hold      = 1'b0;
		regValRs  = '0;
		regValRt  = '0;
		ixt       = '0;
		srLoad    = 1'b0;
		srLoadVal = '0;
		expVal    = '0;
		expValid  = 1'b0;
		expSr     = '0;
		rowIdx    = -1;

		repeat (RESET_CYCLES) @(posedge clock);
		rst <= 1'b0;
		@(negedge clock);
		checkOutputs();

		// row i goes in at this edge while row i-1 is sampled
		for (int i = 0; i <= NUM_ROWS; i++) begin
			@(posedge clock);
			if (i < NUM_ROWS) begin
				pickOperands(ROWS[i].opnd, opRs, opRt);
				issue     <= 1'b1;
				hold      <= ROWS[i].hold;
				ixt       <= ROWS[i].ixt;
				regValRs  <= opRs;
				regValRt  <= opRt;
				srLoad    <= ROWS[i].srLoad;
				srLoadVal <= ROWS[i].loadVal;
			end else begin
				issue  <= 1'b0;
				hold   <= 1'b0;
				srLoad <= 1'b0;
			end

			@(negedge clock);
			if (i > 0) begin
				rowIdx = i - 1;
				if (!ROWS[i-1].hold) begin
					waitValid();
				end
				checkOutputs();
			end

			// a held row leaves every expected value as it was
			if (i < NUM_ROWS && !ROWS[i].hold) begin
				modelOut = aluModel(ROWS[i].ixt, opRs, opRt, expSr);
				expVal   = modelOut.val;
				expValid = 1'b1;
				expSr    = ROWS[i].srLoad ? ROWS[i].loadVal : modelOut.sr;
			end
		end

		// idle cycle where valid drops and the value stays
		rowIdx = NUM_ROWS;
		@(posedge clock);
		@(negedge clock);
		expValid = 1'b0;
		checkOutputs();

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/exAluSlice.sv
// execute-stage ALU slice top, ALU plus its status register
`default_nettype none

module exAluSlice (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 issue,
	input  logic                 hold,
	input  exCorePkg::regVal_t   regValRs,
	input  exCorePkg::regVal_t   regValRt,
	input  exAluOpPkg::aluIxt_t  ixt,
	input  logic                 srLoad,
	input  exCorePkg::srBits_t   srLoadVal,
	output exCorePkg::regVal_t   regOutVal,
	output logic                 outValid,
	output exCorePkg::srBits_t   sr
);

	import exCorePkg::*;

	srBits_t srNext;
	logic    srWrite;

	exAlu u_alu (
		.clock     (clock),
		.rst       (rst),
		.issue     (issue),
		.hold      (hold),
		.regValRs  (regValRs),
		.regValRt  (regValRt),
		.ixt       (ixt),
		.srCur     (sr),
		.srNext    (srNext),
		.srWrite   (srWrite),
		.regOutVal (regOutVal),
		.outValid  (outValid)
	);

	exStatusReg u_sr (
		.clock     (clock),
		.rst       (rst),
		.hold      (hold),
		.srLoad    (srLoad),
		.srLoadVal (srLoadVal),
		.srWrite   (srWrite),
		.srNext    (srNext),
		.sr        (sr)
	);

endmodule

`default_nettype wire

//--- verilog/exStatusReg.sv
// T/S status register feeding carry and select back into the ALU
`default_nettype none

module exStatusReg (
	input  logic                clock,
	input  logic                rst,
	input  logic                hold,
	input  logic                srLoad,
	input  exCorePkg::srBits_t  srLoadVal,
	input  logic                srWrite,
	input  exCorePkg::srBits_t  srNext,
	output exCorePkg::srBits_t  sr
);

	always_ff @(posedge clock) begin
		if (rst) begin
			sr <= '0;
		end else if (!hold) begin
			// external load beats an ALU update in the same cycle
			if (srLoad) begin
				sr <= srLoadVal;
			end else if (srWrite) begin
				sr <= srNext;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exAlu.sv
// integer ALU with width modes and a one-cycle stallable output stage inside the slice top
`default_nettype none

module exAlu (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 issue,
	input  logic                 hold,
	input  exCorePkg::regVal_t   regValRs,
	input  exCorePkg::regVal_t   regValRt,
	input  exAluOpPkg::aluIxt_t  ixt,
	input  exCorePkg::srBits_t   srCur,
	output exCorePkg::srBits_t   srNext,
	output logic                 srWrite,
	output exCorePkg::regVal_t   regOutVal,
	output logic                 outValid
);

	import exCorePkg::*;
	import exAluOpPkg::*;

	sumSet_t   sums;
	aluFlags_t lo32;
	aluFlags_t hi32;
	aluFlags_t full64;
	logic      tstLo;
	logic      tstHi;
	logic      tst64;

	regVal_t  logicVal;
	laneSum_t resLo;
	laneSum_t resHi;
	regSum_t  res64;
	logic     tLo;
	logic     t64;
	logic     sHi;
	laneVal_t laneLo;
	laneVal_t laneHi;
	regVal_t  aluVal;

	exCarrySelectAdder u_adder (
		.regValRs (regValRs),
		.regValRt (regValRt),
		.sums     (sums)
	);

	exCompareFlags u_flags (
		.regValRs (regValRs),
		.regValRt (regValRt),
		.sums     (sums),
		.lo32     (lo32),
		.hi32     (hi32),
		.full64   (full64),
		.tstLo    (tstLo),
		.tstHi    (tstHi),
		.tst64    (tst64)
	);

	always_comb begin
		case (ixt.op)
			OP_AND:  logicVal = regValRs & regValRt;
			OP_OR:   logicVal = regValRs | regValRt;
			OP_XOR:  logicVal = regValRs ^ regValRt;
			OP_NOR:  logicVal = ~(regValRs | regValRt);
			default: logicVal = '0;
		endcase
	end

	// per-op lane results with tLo and t64 for T and sHi for the packed S
	always_comb begin
		resLo = '0;
		resHi = '0;
		res64 = '0;
		tLo   = srCur.t;
		t64   = srCur.t;
		sHi   = srCur.s;

		case (ixt.op)
			OP_ADD: begin
				resLo = sums.add32Ci0;
				resHi = sums.addHiCi0;
				res64 = sums.add64Ci0;
			end
			OP_SUB: begin
				resLo = sums.sub32Ci1;
				resHi = sums.subHiCi1;
				res64 = sums.sub64Ci1;
			end
			OP_ADC: begin
				resLo = srCur.t ? sums.add32Ci1 : sums.add32Ci0;
				resHi = srCur.s ? sums.addHiCi1 : sums.addHiCi0;
				res64 = srCur.t ? sums.add64Ci1 : sums.add64Ci0;
				tLo   = resLo[LANE_WIDTH];
				sHi   = resHi[LANE_WIDTH];
				t64   = res64[REG_WIDTH];
			end
			OP_SBB: begin
				// a set flag is a pending borrow
				resLo = srCur.t ? sums.sub32Ci0 : sums.sub32Ci1;
				resHi = srCur.s ? sums.subHiCi0 : sums.subHiCi1;
				res64 = srCur.t ? sums.sub64Ci0 : sums.sub64Ci1;
				tLo   = !resLo[LANE_WIDTH];
				sHi   = !resHi[LANE_WIDTH];
				t64   = !res64[REG_WIDTH];
			end
			OP_AND, OP_OR, OP_XOR, OP_NOR: begin
				resLo = {1'b0, logicVal[LANE_WIDTH-1:0]};
				resHi = {1'b0, logicVal[REG_WIDTH-1:LANE_WIDTH]};
				res64 = {1'b0, logicVal};
			end
			OP_TST: begin
				tLo = tstLo;
				sHi = tstHi;
				t64 = tst64;
			end
			OP_CMPNE: begin
				tLo = !lo32.z;
				sHi = !hi32.z;
				t64 = !full64.z;
			end
			OP_CMPHS: begin
				// carry out of Rs - Rt means no borrow
				tLo = lo32.c;
				sHi = hi32.c;
				t64 = full64.c;
			end
			OP_CMPGE: begin
				tLo = !(lo32.s ^ lo32.v);
				sHi = !(hi32.s ^ hi32.v);
				t64 = !(full64.s ^ full64.v);
			end
			OP_CMPEQ: begin
				tLo = lo32.z;
				sHi = hi32.z;
				t64 = full64.z;
			end
			OP_CMPHI: begin
				tLo = lo32.c && !lo32.z;
				sHi = hi32.c && !hi32.z;
				t64 = full64.c && !full64.z;
			end
			OP_CMPGT: begin
				tLo = !(lo32.s ^ lo32.v) && !lo32.z;
				sHi = !(hi32.s ^ hi32.v) && !hi32.z;
				t64 = !(full64.s ^ full64.v) && !full64.z;
			end
			OP_CSELT: begin
				resLo = {1'b0, srCur.t ? regValRs[LANE_WIDTH-1:0] : regValRt[LANE_WIDTH-1:0]};
				resHi = {1'b0, srCur.s ? regValRs[REG_WIDTH-1:LANE_WIDTH] :
					regValRt[REG_WIDTH-1:LANE_WIDTH]};
				res64 = {1'b0, srCur.t ? regValRs : regValRt};
			end
		endcase
	end

	// width mode picks the value and which status bits move
	always_comb begin
		laneLo = resLo[LANE_WIDTH-1:0];
		laneHi = resHi[LANE_WIDTH-1:0];
		srNext = srCur;

		if (ixt.qword && ixt.zext) begin
			aluVal   = {laneHi, laneLo};
			srNext.t = tLo;
			srNext.s = sHi;
		end else if (ixt.qword) begin
			aluVal   = res64[REG_WIDTH-1:0];
			srNext.t = t64;
		end else if (ixt.zext) begin
			aluVal   = {{LANE_WIDTH{1'b0}}, laneLo};
			srNext.t = tLo;
		end else begin
			aluVal   = {{LANE_WIDTH{laneLo[LANE_WIDTH-1]}}, laneLo};
			srNext.t = tLo;
		end
	end

	assign srWrite = issue && !hold;

	always_ff @(posedge clock) begin
		if (rst) begin
			regOutVal <= '0;
			outValid  <= 1'b0;
		end else if (!hold) begin
			outValid <= issue;
			if (issue) begin
				regOutVal <= aluVal;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/exCompareFlags.sv
// compare and test flags for the low lane, the high lane and the full register
`default_nettype none

module exCompareFlags (
	input  exCorePkg::regVal_t    regValRs,
	input  exCorePkg::regVal_t    regValRt,
	input  exAluOpPkg::sumSet_t   sums,
	output exCorePkg::aluFlags_t  lo32,
	output exCorePkg::aluFlags_t  hi32,
	output exCorePkg::aluFlags_t  full64,
	output logic                  tstLo,
	output logic                  tstHi,
	output logic                  tst64
);

	import exCorePkg::*;

	localparam int LANE_TOP = LANE_WIDTH - 1;
	localparam int REG_TOP  = REG_WIDTH - 1;

	// adder inputs Rs and ~Rt share a sign that the result lacks
	function automatic logic overflow(logic signRs, logic signRt, logic signRes);
		return (signRs ^ signRt) & (signRs ^ signRes);
	endfunction

	// all flags come from the carry-in 1 subtract Rs - Rt
	always_comb begin
		lo32.z = (sums.sub32Ci1[LANE_TOP:0] == '0);
		lo32.c = sums.sub32Ci1[LANE_WIDTH];
		lo32.s = sums.sub32Ci1[LANE_TOP];
		lo32.v = overflow(regValRs[LANE_TOP], regValRt[LANE_TOP], lo32.s);

		hi32.z = (sums.subHiCi1[LANE_TOP:0] == '0);
		hi32.c = sums.subHiCi1[LANE_WIDTH];
		hi32.s = sums.subHiCi1[LANE_TOP];
		hi32.v = overflow(regValRs[REG_TOP], regValRt[REG_TOP], hi32.s);

		full64.z = (sums.sub64Ci1[REG_TOP:0] == '0);
		full64.c = sums.sub64Ci1[REG_WIDTH];
		full64.s = sums.sub64Ci1[REG_TOP];
		full64.v = overflow(regValRs[REG_TOP], regValRt[REG_TOP], full64.s);
	end

	// TST is true when no bit is common to both operands
	always_comb begin
		tstLo = ((regValRs[LANE_TOP:0] & regValRt[LANE_TOP:0]) == '0);
		tstHi = ((regValRs[REG_TOP:LANE_WIDTH] & regValRt[REG_TOP:LANE_WIDTH]) == '0);
		tst64 = tstLo && tstHi;
	end

endmodule

`default_nettype wire

//--- verilog/exCarrySelectAdder.sv
// carry-select adder giving all add and subtract sums the ALU may pick from
`default_nettype none

module exCarrySelectAdder (
	input  exCorePkg::regVal_t   regValRs,
	input  exCorePkg::regVal_t   regValRt,
	output exAluOpPkg::sumSet_t  sums
);

	import exCorePkg::*;

	typedef logic [16:0] chunkSum_t;

	// first index is the chunk carry-in, second the 16-bit chunk
	chunkSum_t addChunk [2][4];
	chunkSum_t subChunk [2][4];

	// per carry-in into the lane
	laneSum_t addLo [2];
	laneSum_t addHi [2];
	laneSum_t subLo [2];
	laneSum_t subHi [2];

	function automatic laneSum_t joinChunks(chunkSum_t lo, chunkSum_t hi0, chunkSum_t hi1);
		return {lo[16] ? hi1 : hi0, lo[15:0]};
	endfunction

	function automatic regSum_t joinLanes(laneSum_t lo, laneSum_t hi0, laneSum_t hi1);
		return {lo[LANE_WIDTH] ? hi1 : hi0, lo[LANE_WIDTH-1:0]};
	endfunction

	always_comb begin
		for (int c = 0; c < 2; c++) begin
			for (int i = 0; i < 4; i++) begin
				addChunk[c][i] = {1'b0, regValRs[i*16 +: 16]} +
					{1'b0, regValRt[i*16 +: 16]} + 17'(c);
				subChunk[c][i] = {1'b0, regValRs[i*16 +: 16]} +
					{1'b0, ~regValRt[i*16 +: 16]} + 17'(c);
			end
		end

		// chunk carry picks the precomputed upper half
		for (int c = 0; c < 2; c++) begin
			addLo[c] = joinChunks(addChunk[c][0], addChunk[0][1], addChunk[1][1]);
			addHi[c] = joinChunks(addChunk[c][2], addChunk[0][3], addChunk[1][3]);
			subLo[c] = joinChunks(subChunk[c][0], subChunk[0][1], subChunk[1][1]);
			subHi[c] = joinChunks(subChunk[c][2], subChunk[0][3], subChunk[1][3]);
		end

		sums.add32Ci0 = addLo[0];
		sums.add32Ci1 = addLo[1];
		sums.sub32Ci0 = subLo[0];
		sums.sub32Ci1 = subLo[1];

		sums.add64Ci0 = joinLanes(addLo[0], addHi[0], addHi[1]);
		sums.add64Ci1 = joinLanes(addLo[1], addHi[0], addHi[1]);
		sums.sub64Ci0 = joinLanes(subLo[0], subHi[0], subHi[1]);
		sums.sub64Ci1 = joinLanes(subLo[1], subHi[0], subHi[1]);

		// packed high lane keeps its own carry-in
		sums.addHiCi0 = addHi[0];
		sums.addHiCi1 = addHi[1];
		sums.subHiCi0 = subHi[0];
		sums.subHiCi1 = subHi[1];
	end

endmodule

`default_nettype wire

//--- verilog/exAluOpPkg.sv
// ALU opcode encoding and adder result bundle shared by the ALU and its helpers
`default_nettype none

package exAluOpPkg;

	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_ADC   = 4'h2,
		OP_SBB   = 4'h3,
		OP_TST   = 4'h4,
		OP_AND   = 4'h5,
		OP_OR    = 4'h6,
		OP_XOR   = 4'h7,
		OP_CMPNE = 4'h8,
		OP_CMPHS = 4'h9,
		OP_CMPGE = 4'hA,
		OP_NOR   = 4'hB,
		OP_CMPEQ = 4'hC,
		OP_CMPHI = 4'hD,
		OP_CMPGT = 4'hE,
		OP_CSELT = 4'hF
	} aluOp_t;

	// extended opcode byte, cc in the top two bits
	typedef struct packed {
		logic [1:0] cc;
		logic       qword;
		logic       zext;
		aluOp_t     op;
	} aluIxt_t;

	// subtract sums are Rs + ~Rt, so carry-in 1 is a true subtract
	typedef struct packed {
		exCorePkg::laneSum_t add32Ci0;
		exCorePkg::laneSum_t add32Ci1;
		exCorePkg::laneSum_t sub32Ci0;
		exCorePkg::laneSum_t sub32Ci1;
		exCorePkg::regSum_t  add64Ci0;
		exCorePkg::regSum_t  add64Ci1;
		exCorePkg::regSum_t  sub64Ci0;
		exCorePkg::regSum_t  sub64Ci1;
		exCorePkg::laneSum_t addHiCi0;
		exCorePkg::laneSum_t addHiCi1;
		exCorePkg::laneSum_t subHiCi0;
		exCorePkg::laneSum_t subHiCi1;
	} sumSet_t;

endpackage

`default_nettype wire

//--- verilog/exCorePkg.sv
// core datapath widths and status types, imported by every execute-stage block
`default_nettype none

package exCorePkg;

	localparam int REG_WIDTH  = 64;
	localparam int LANE_WIDTH = 32;

	// full register and one packed lane
	typedef logic [REG_WIDTH-1:0]  regVal_t;
	typedef logic [LANE_WIDTH-1:0] laneVal_t;

	// sums with their carry-out on top
	typedef logic [LANE_WIDTH:0] laneSum_t;
	typedef logic [REG_WIDTH:0]  regSum_t;

	// status register, S above T as on the two-bit port
	typedef struct packed {
		logic s;
		logic t;
	} srBits_t;

	// compare flags of one width
	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} aluFlags_t;

endpackage

`default_nettype wire
